// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = ahb_dual_mem_tb
FILELIST = filelist.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// File: filelist.f
hw/ahb_pkg.sv
hw/mem_map_pkg.sv
hw/ready_gen.sv
hw/mem_array.sv
hw/imem_port.sv
hw/dmem_port.sv
hw/ahb_dual_mem.sv
sim/tb_clk_gen.sv
sim/ahb_dual_mem_tb.sv

// File: hw/ahb_dual_mem.sv
/*
 * Dual-port AHB-Lite memory model
 * Instruction and data ports, two ready sources, shared byte array
 */
`default_nettype none

module ahb_dual_mem import ahb_pkg::*; #(
    parameter int MEM_ADDR_BITS = 12,
    parameter int IRQ_LINES     = 8
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire  [31:0]          imem_stall_pattern,
    input  wire  [31:0]          dmem_stall_pattern,
    // Instruction port
    input  wire  htrans_t        imem_htrans,
    input  wire  hsize_t         imem_hsize,
    input  wire  [AHB_W-1:0]     imem_haddr,
    output logic                 imem_hready,
    output logic                 imem_hresp,
    output logic [AHB_W-1:0]     imem_hrdata,
    // Data port
    input  wire  htrans_t        dmem_htrans,
    input  wire  hsize_t         dmem_hsize,
    input  wire  [AHB_W-1:0]     dmem_haddr,
    input  wire                  dmem_hwrite,
    input  wire  [AHB_W-1:0]     dmem_hwdata,
    output logic                 dmem_hready,
    output logic                 dmem_hresp,
    output logic [AHB_W-1:0]     dmem_hrdata,
    output logic [IRQ_LINES-1:0] irq_lines
);

    logic [AHB_W-1:0] mem_err_ptr;
    logic [AHB_W-1:0] imem_rd_addr;
    be_t              imem_rd_be;
    logic [AHB_W-1:0] imem_rd_data;
    logic [AHB_W-1:0] dmem_rd_addr;
    be_t              dmem_rd_be;
    logic [AHB_W-1:0] dmem_rd_data;
    logic             wr_en;
    logic [AHB_W-1:0] wr_addr;
    be_t              wr_be;
    logic [AHB_W-1:0] wr_data;

    //------------------------------------------------------------
    // Ready sources, one per port
    //------------------------------------------------------------
    ready_gen u_imem_ready (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_pattern (imem_stall_pattern),
        .req_ack       (imem_hready)
    );

    ready_gen u_dmem_ready (
        .clk           (clk),
        .rst_n         (rst_n),
        .stall_pattern (dmem_stall_pattern),
        .req_ack       (dmem_hready)
    );

    //------------------------------------------------------------
    // Ports and array
    //------------------------------------------------------------
    imem_port u_imem_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .hready      (imem_hready),
        .htrans      (imem_htrans),
        .hsize       (imem_hsize),
        .haddr       (imem_haddr),
        .hresp       (imem_hresp),
        .hrdata      (imem_hrdata),
        .mem_err_ptr (mem_err_ptr),
        .rd_addr     (imem_rd_addr),
        .rd_be       (imem_rd_be),
        .rd_data     (imem_rd_data)
    );

    dmem_port #(
        .IRQ_LINES (IRQ_LINES)
    ) u_dmem_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .hready      (dmem_hready),
        .htrans      (dmem_htrans),
        .hsize       (dmem_hsize),
        .haddr       (dmem_haddr),
        .hwrite      (dmem_hwrite),
        .hwdata      (dmem_hwdata),
        .hresp       (dmem_hresp),
        .hrdata      (dmem_hrdata),
        .irq_lines   (irq_lines),
        .mem_err_ptr (mem_err_ptr),
        .rd_addr     (dmem_rd_addr),
        .rd_be       (dmem_rd_be),
        .rd_data     (dmem_rd_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_be       (wr_be),
        .wr_data     (wr_data)
    );

    // Port A serves fetches, port B data reads
    mem_array #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS)
    ) u_mem_array (
        .clk       (clk),
        .rd_a_addr (imem_rd_addr),
        .rd_a_be   (imem_rd_be),
        .rd_a_data (imem_rd_data),
        .rd_b_addr (dmem_rd_addr),
        .rd_b_be   (dmem_rd_be),
        .rd_b_data (dmem_rd_data),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_be     (wr_be),
        .wr_data   (wr_data)
    );

endmodule

`default_nettype wire

// File: hw/ahb_pkg.sv
/*
 * AHB-Lite transfer, size and response encodings
 * Bus width and byte-lane mask type
 * Byte-lane helper shared by both memory ports
 */
`default_nettype none

package ahb_pkg;

    // Bus and address width
    localparam int AHB_W = 32;

    // Only single transfers are modelled, the other codes are illegal
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_NONSEQ = 2'b10
    } htrans_t;

    typedef enum logic [2:0] {
        HSIZE_8B  = 3'b000,
        HSIZE_16B = 3'b001,
        HSIZE_32B = 3'b010
    } hsize_t;

    localparam logic HRESP_OKAY  = 1'b0;
    localparam logic HRESP_ERROR = 1'b1;

    typedef logic [3:0] be_t;

    // Byte lanes from address offset and transfer size
    function automatic be_t be_form(input logic [1:0] offset, input hsize_t hsize);
        be_t lanes;
        case (hsize)
            HSIZE_8B:  lanes = be_t'(4'b0001 << offset);
            HSIZE_16B: lanes = be_t'(4'b0011 << offset);
            HSIZE_32B: lanes = 4'b1111;
            default:   lanes = 4'b0000;
        endcase
        return lanes;
    endfunction

endpackage

`default_nettype wire

// File: hw/dmem_port.sv
/*
 * Data port, read and write
 * Phase tracking, reserved registers, array write issue
 */
`default_nettype none

module dmem_port import ahb_pkg::*, mem_map_pkg::*; #(
    parameter int IRQ_LINES = 8
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  hready,
    input  wire  htrans_t        htrans,
    input  wire  hsize_t         hsize,
    input  wire  [AHB_W-1:0]     haddr,
    input  wire                  hwrite,
    input  wire  [AHB_W-1:0]     hwdata,
    output logic                 hresp,
    output logic [AHB_W-1:0]     hrdata,
    output logic [IRQ_LINES-1:0] irq_lines,
    output logic [AHB_W-1:0]     mem_err_ptr,
    output logic [AHB_W-1:0]     rd_addr,
    output be_t                  rd_be,
    input  wire  [AHB_W-1:0]     rd_data,
    output logic                 wr_en,
    output logic [AHB_W-1:0]     wr_addr,
    output be_t                  wr_be,
    output logic [AHB_W-1:0]     wr_data
);

    logic                 accept;
    be_t                  be;
    logic                 data_phase_q;
    logic [AHB_W-1:0]     addr_q;
    logic                 write_q;
    be_t                  be_q;
    logic [AHB_W-1:0]     rdata_q;
    logic [IRQ_LINES-1:0] irq_q;
    logic [AHB_W-1:0]     err_ptr_q;
    logic                 addr_err;
    logic                 commit;
    logic [IRQ_LINES-1:0] irq_nxt;
    logic [AHB_W-1:0]     err_ptr_nxt;
    logic [AHB_W-1:0]     rd_value;

    assign accept = hready && (htrans == HTRANS_NONSEQ);
    assign be     = be_form(haddr[1:0], hsize);

    assign rd_addr = haddr;
    assign rd_be   = be;

    //------------------------------------------------------------
    // Write issue
    //------------------------------------------------------------
    assign addr_err = (addr_q == MEM_ERR_ADDR) || (addr_q == err_ptr_q);

    // Last cycle of a write data phase
    assign commit = data_phase_q && hready && write_q && !addr_err;

    assign wr_en   = commit && (addr_q != IRQ_ADDR) && (addr_q != MEM_ERR_PTR_ADDR);
    assign wr_addr = addr_q;
    assign wr_be   = be_q;
    assign wr_data = hwdata;

    // Register values after this edge, so back-to-back reads see the write
    assign irq_nxt     = (commit && (addr_q == IRQ_ADDR)) ? hwdata[IRQ_LINES-1:0] : irq_q;
    assign err_ptr_nxt = (commit && (addr_q == MEM_ERR_PTR_ADDR)) ? hwdata : err_ptr_q;

    always_comb begin
        case (haddr)
            IRQ_ADDR:         rd_value = AHB_W'(irq_nxt);
            MEM_ERR_PTR_ADDR: rd_value = err_ptr_nxt;
            default:          rd_value = rd_data;
        endcase
    end

    //------------------------------------------------------------
    // Control state
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_phase_q <= 1'b0;
            irq_q        <= '0;
            err_ptr_q    <= MEM_ERR_PTR_RESET;
        end else begin
            if (hready) begin
                data_phase_q <= accept;
            end
            irq_q     <= irq_nxt;
            err_ptr_q <= err_ptr_nxt;
        end
    end

    // Address phase latch, held under back-pressure
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= haddr;
            write_q <= hwrite;
            be_q    <= be;
            rdata_q <= rd_value;
        end
    end

    //------------------------------------------------------------
    // Response
    //------------------------------------------------------------
    assign hresp  = (data_phase_q && addr_err) ? HRESP_ERROR : HRESP_OKAY;
    assign hrdata = (data_phase_q && !write_q && !addr_err) ? rdata_q : '0;

    assign irq_lines   = irq_q;
    assign mem_err_ptr = err_ptr_q;

    a_htrans_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        htrans inside {HTRANS_IDLE, HTRANS_NONSEQ}
    );

endmodule

`default_nettype wire

// File: hw/imem_port.sv
/*
 * Instruction port, read only
 * Address and data phase tracking, read data latch, error response
 */
`default_nettype none

module imem_port import ahb_pkg::*, mem_map_pkg::*; (
    input  wire              clk,
    input  wire              rst_n,
    input  wire              hready,
    input  wire  htrans_t    htrans,
    input  wire  hsize_t     hsize,
    input  wire  [AHB_W-1:0] haddr,
    output logic             hresp,
    output logic [AHB_W-1:0] hrdata,
    input  wire  [AHB_W-1:0] mem_err_ptr,
    output logic [AHB_W-1:0] rd_addr,
    output be_t              rd_be,
    input  wire  [AHB_W-1:0] rd_data
);

    logic             accept;
    logic             data_phase_q;
    logic [AHB_W-1:0] addr_q;
    logic [AHB_W-1:0] rdata_q;
    logic             addr_err;

    assign accept = hready && (htrans == HTRANS_NONSEQ);

    // Word fetch, the address offset is ignored
    assign rd_addr = {haddr[AHB_W-1:2], 2'b00};
    assign rd_be   = be_form(2'b00, hsize);

    //------------------------------------------------------------
    // Phase tracking
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_phase_q <= 1'b0;
        end else if (hready) begin
            data_phase_q <= accept;
        end
    end

    // Held through wait states
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q  <= haddr;
            rdata_q <= rd_data;
        end
    end

    //------------------------------------------------------------
    // Response
    //------------------------------------------------------------
    assign addr_err = (addr_q == MEM_ERR_ADDR) || (addr_q == mem_err_ptr);
    assign hresp    = (data_phase_q && addr_err) ? HRESP_ERROR : HRESP_OKAY;
    assign hrdata   = (data_phase_q && !addr_err) ? rdata_q : '0;

    a_htrans_legal: assert property (
        @(posedge clk) disable iff (!rst_n)
        htrans inside {HTRANS_IDLE, HTRANS_NONSEQ}
    );

    // Fetches are always full words
    a_hsize_word: assert property (
        @(posedge clk) disable iff (!rst_n)
        accept |-> (hsize == HSIZE_32B)
    );

endmodule

`default_nettype wire

// File: hw/mem_array.sv
/*
 * Byte-addressed array, two read ports and one write port
 * Lane-masked reads with same-word write bypass
 */
`default_nettype none

module mem_array import ahb_pkg::*; #(
    parameter int MEM_ADDR_BITS = 12
) (
    input  wire              clk,
    input  wire  [AHB_W-1:0] rd_a_addr,
    input  wire  be_t        rd_a_be,
    output logic [AHB_W-1:0] rd_a_data,
    input  wire  [AHB_W-1:0] rd_b_addr,
    input  wire  be_t        rd_b_be,
    output logic [AHB_W-1:0] rd_b_data,
    input  wire              wr_en,
    input  wire  [AHB_W-1:0] wr_addr,
    input  wire  be_t        wr_be,
    input  wire  [AHB_W-1:0] wr_data
);

    // Addresses wrap modulo the array size
    logic [7:0] mem [2**MEM_ADDR_BITS];

    // One word read, unselected lanes zero, writing lanes bypassed
    function automatic logic [AHB_W-1:0] read_word(
        input logic [AHB_W-1:0] addr,
        input be_t              be
    );
        logic [AHB_W-1:0] word;
        logic             hit;
        hit  = wr_en && (wr_addr[MEM_ADDR_BITS-1:2] == addr[MEM_ADDR_BITS-1:2]);
        word = '0;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                if (hit && wr_be[i]) begin
                    word[8*i +: 8] = wr_data[8*i +: 8];
                end else begin
                    word[8*i +: 8] = mem[{addr[MEM_ADDR_BITS-1:2], 2'(i)}];
                end
            end
        end
        return word;
    endfunction

    //------------------------------------------------------------
    // Read ports
    //------------------------------------------------------------
    always_comb begin
        rd_a_data = read_word(rd_a_addr, rd_a_be);
    end

    always_comb begin
        rd_b_data = read_word(rd_b_addr, rd_b_be);
    end

    //------------------------------------------------------------
    // Write port
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) begin
                    mem[{wr_addr[MEM_ADDR_BITS-1:2], 2'(i)}] <= wr_data[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_map_pkg.sv
/*
 * Reserved addresses of the memory model
 * Error address, interrupt register and error pointer
 */
`default_nettype none

package mem_map_pkg;

    //------------------------------------------------------------
    // Reserved locations
    //------------------------------------------------------------

    // Always answered with an ERROR response
    localparam logic [31:0] MEM_ERR_ADDR = 32'hffff_f100;

    // Interrupt-line register, data port only
    localparam logic [31:0] IRQ_ADDR = 32'hf000_0100;

    // Programmable error pointer, data port only
    localparam logic [31:0] MEM_ERR_PTR_ADDR = 32'hf000_0200;

    // Pointer starts on the fixed error address
    localparam logic [31:0] MEM_ERR_PTR_RESET = MEM_ERR_ADDR;

endpackage

`default_nettype wire

// File: hw/ready_gen.sv
/*
 * Per-port ready source
 * Rotating 32-bit stall pattern, 16-bit LFSR when the pattern is zero
 */
`default_nettype none

module ready_gen (
    input  wire         clk,
    input  wire         rst_n,
    input  wire  [31:0] stall_pattern,
    output logic        req_ack
);

    logic [31:0] pattern_q;
    logic [15:0] lfsr_q;
    logic        use_lfsr;
    logic        lfsr_fb;

    assign use_lfsr = (pattern_q == 32'd0);

    // Taps 16, 14, 13, 11 for a maximal-length sequence
    assign lfsr_fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    //------------------------------------------------------------
    // Pattern and LFSR state
    //------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Pattern is reloaded on every reset cycle
            pattern_q <= stall_pattern;
            lfsr_q    <= 16'hace1;
        end else if (use_lfsr) begin
            lfsr_q <= {lfsr_q[14:0], lfsr_fb};
        end else begin
            pattern_q <= {pattern_q[0], pattern_q[31:1]};
        end
    end

    assign req_ack = use_lfsr ? lfsr_q[15] : pattern_q[0];

endmodule

`default_nettype wire

// File: sim/ahb_dual_mem_tb.sv
/*
 * Testbench for the dual-port AHB-Lite memory model
 * Replays the transfer trace on both ports
 * Checks read data, responses, ready and interrupt lines
 */
`default_nettype none

module ahb_dual_mem_tb import ahb_pkg::*, mem_map_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          MEM_ADDR_BITS = 12;
    localparam int          IRQ_LINES     = 8;
    localparam int          MAX_TR        = 64;
    localparam int          READY_TIMEOUT = 64;
    localparam int          RESET_TIMEOUT = 32;
    localparam logic [31:0] IMEM_PATTERN  = 32'hdb6d_b6dd;
    localparam logic [31:0] DMEM_PATTERN  = 32'h96a5_5a69;
    localparam logic [31:0] SEED          = 32'hf98e_fffa;

    logic                 clk;
    logic                 rst_n;
    logic [31:0]          imem_stall_pattern;
    logic [31:0]          dmem_stall_pattern;
    htrans_t              imem_htrans;
    hsize_t               imem_hsize;
    logic [AHB_W-1:0]     imem_haddr;
    logic                 imem_hready;
    logic                 imem_hresp;
    logic [AHB_W-1:0]     imem_hrdata;
    htrans_t              dmem_htrans;
    hsize_t               dmem_hsize;
    logic [AHB_W-1:0]     dmem_haddr;
    logic                 dmem_hwrite;
    logic [AHB_W-1:0]     dmem_hwdata;
    logic                 dmem_hready;
    logic                 dmem_hresp;
    logic [AHB_W-1:0]     dmem_hrdata;
    logic [IRQ_LINES-1:0] irq_lines;

    // Trace contents per transfer
    int                   tr_port  [MAX_TR];
    int                   tr_write [MAX_TR];
    int                   tr_size  [MAX_TR];
    int                   tr_chain [MAX_TR];
    logic [AHB_W-1:0]     tr_addr  [MAX_TR];
    logic [AHB_W-1:0]     tr_wdata [MAX_TR];
    logic [AHB_W-1:0]     tr_rdata [MAX_TR];
    logic                 tr_resp  [MAX_TR];
    int                   tr_count;

    int                   error_count;
    int                   fail_tests;
    int                   tests_run;
    logic [IRQ_LINES-1:0] irq_model;
    logic [31:0]          imem_ready_exp;
    logic [31:0]          dmem_ready_exp;

    tb_clk_gen #(
        .PERIOD_NS    (10),
        .RESET_CYCLES (8)
    ) u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    ahb_dual_mem #(
        .MEM_ADDR_BITS (MEM_ADDR_BITS),
        .IRQ_LINES     (IRQ_LINES)
    ) DUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .imem_stall_pattern (imem_stall_pattern),
        .dmem_stall_pattern (dmem_stall_pattern),
        .imem_htrans        (imem_htrans),
        .imem_hsize         (imem_hsize),
        .imem_haddr         (imem_haddr),
        .imem_hready        (imem_hready),
        .imem_hresp         (imem_hresp),
        .imem_hrdata        (imem_hrdata),
        .dmem_htrans        (dmem_htrans),
        .dmem_hsize         (dmem_hsize),
        .dmem_haddr         (dmem_haddr),
        .dmem_hwrite        (dmem_hwrite),
        .dmem_hwdata        (dmem_hwdata),
        .dmem_hready        (dmem_hready),
        .dmem_hresp         (dmem_hresp),
        .dmem_hrdata        (dmem_hrdata),
        .irq_lines          (irq_lines)
    );

    //------------------------------------------------------------
    // Compare tasks
    //------------------------------------------------------------
    task automatic check_rdata(input string name, input logic [AHB_W-1:0] got,
                               input logic [AHB_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_resp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_irq(input string name, input logic [IRQ_LINES-1:0] got,
                             input logic [IRQ_LINES-1:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    //------------------------------------------------------------
    // Ready pattern reference
    //------------------------------------------------------------
    // Each pattern rotates right once per clock after reset
    always @(posedge clk) begin
        if (!rst_n) begin
            imem_ready_exp <= IMEM_PATTERN;
            dmem_ready_exp <= DMEM_PATTERN;
        end else begin
            imem_ready_exp <= {imem_ready_exp[0], imem_ready_exp[31:1]};
            dmem_ready_exp <= {dmem_ready_exp[0], dmem_ready_exp[31:1]};
        end
    end

    always @(negedge clk) begin
        if (rst_n === 1'b1) begin
            check_ready("imem_hready", imem_hready, imem_ready_exp[0]);
            check_ready("dmem_hready", dmem_hready, dmem_ready_exp[0]);
        end
    end

    //------------------------------------------------------------
    // Trace loading
    //------------------------------------------------------------
    task automatic read_trace();
        int               fd;
        int               fields;
        string            line;
        int               port;
        int               write;
        int               size;
        int               resp;
        int               chain;
        logic [AHB_W-1:0] addr;
        logic [AHB_W-1:0] wdata;
        logic [AHB_W-1:0] rdata;
        tr_count = 0;
        fd = $fopen("sim/ahb_dual_mem_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file");
            error_count++;
            return;
        end
        while (!$feof(fd) && tr_count < MAX_TR) begin
            line = "";
            void'($fgets(line, fd));
            // Comment and blank lines match no field
            fields = $sscanf(line, "%d %d %d %h %h %h %d %d",
                             port, write, size, addr, wdata, rdata, resp, chain);
            if (fields == 8) begin
                tr_port[tr_count]  = port;
                tr_write[tr_count] = write;
                tr_size[tr_count]  = size;
                tr_chain[tr_count] = chain;
                tr_addr[tr_count]  = addr;
                tr_wdata[tr_count] = wdata;
                tr_rdata[tr_count] = rdata;
                tr_resp[tr_count]  = resp[0];
                tr_count++;
            end
        end
        $fclose(fd);
    endtask

    //------------------------------------------------------------
    // Bus driving
    //------------------------------------------------------------
    // Pipelined behind the previous transfer on the same port
    function automatic bit is_chained(input int i);
        return (i > 0) && (tr_chain[i] != 0) && (tr_port[i] == tr_port[i - 1]);
    endfunction

    task automatic drive_addr(input int i);
        if (tr_port[i] == 0) begin
            imem_htrans <= HTRANS_NONSEQ;
            imem_hsize  <= hsize_t'(3'(tr_size[i]));
            imem_haddr  <= tr_addr[i];
        end else begin
            dmem_htrans <= HTRANS_NONSEQ;
            dmem_hsize  <= hsize_t'(3'(tr_size[i]));
            dmem_haddr  <= tr_addr[i];
            dmem_hwrite <= (tr_write[i] != 0);
        end
    endtask

    task automatic drive_idle(input int port);
        if (port == 0) begin
            imem_htrans <= HTRANS_IDLE;
        end else begin
            dmem_htrans <= HTRANS_IDLE;
            dmem_hwrite <= 1'b0;
        end
    endtask

    // Returns on a falling edge with hready high before the completing rising edge
    task automatic wait_ready(input int port, output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            if ((port == 0) ? imem_hready : dmem_hready) begin
                ok = 1'b1;
            end else begin
                cycles++;
            end
        end
        if (!ok) begin
            $display("timeout: %s port hready stayed low for %0d cycles",
                     (port == 0) ? "instruction" : "data", READY_TIMEOUT);
            error_count++;
        end
    endtask

    task automatic wait_reset(output bit ok);
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (rst_n === 1'b1);
        if (!ok) begin
            $display("reset was never released");
            error_count++;
        end
    endtask

    //------------------------------------------------------------
    // Transfer checking and replay
    //------------------------------------------------------------
    task automatic check_result(input int i);
        if (tr_port[i] == 0) begin
            check_resp("imem_hresp", imem_hresp, tr_resp[i]);
            check_rdata("imem_hrdata", imem_hrdata, tr_rdata[i]);
        end else begin
            check_resp("dmem_hresp", dmem_hresp, tr_resp[i]);
            if (tr_write[i] == 0) begin
                check_rdata("dmem_hrdata", dmem_hrdata, tr_rdata[i]);
            end
        end
        check_irq("irq_lines", irq_lines, irq_model);
        // Register takes the write on the edge that ends this data phase
        if (tr_port[i] != 0 && tr_write[i] != 0 && tr_addr[i] == IRQ_ADDR
                && tr_resp[i] == HRESP_OKAY) begin
            irq_model = tr_wdata[i][IRQ_LINES-1:0];
        end
    endtask

    task automatic replay_trace();
        int gap;
        int errs_before;
        bit ok;
        for (int i = 0; i < tr_count; i++) begin
            errs_before = error_count;
            ok          = 1'b1;
            if (!is_chained(i)) begin
                gap = int'($urandom_range(3, 0));
                repeat (gap + 1) @(posedge clk);
                drive_addr(i);
                wait_ready(tr_port[i], ok);
            end
            if (ok) begin
                // Address phase accepted here
                @(posedge clk);
                if (tr_write[i] != 0) begin
                    dmem_hwdata <= tr_wdata[i];
                end
                if (i + 1 < tr_count && is_chained(i + 1)) begin
                    drive_addr(i + 1);
                end else begin
                    drive_idle(tr_port[i]);
                end
                wait_ready(tr_port[i], ok);
            end
            if (ok) begin
                check_result(i);
            end
            tests_run++;
            if (error_count != errs_before) begin
                fail_tests++;
            end
            $display("test %0d %s %s addr %h: %s", i, (tr_port[i] == 0) ? "imem" : "dmem",
                     (tr_write[i] != 0) ? "write" : "read", tr_addr[i],
                     (error_count == errs_before) ? "passed" : "FAILED");
            if (!ok) begin
                break;
            end
        end
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial begin
        bit ok;
        error_count = 0;
        fail_tests  = 0;
        tests_run   = 0;
        irq_model   = '0;

        imem_stall_pattern <= IMEM_PATTERN;
        dmem_stall_pattern <= DMEM_PATTERN;
        imem_htrans        <= HTRANS_IDLE;
        imem_hsize         <= HSIZE_32B;
        imem_haddr         <= '0;
        dmem_htrans        <= HTRANS_IDLE;
        dmem_hsize         <= HSIZE_32B;
        dmem_haddr         <= '0;
        dmem_hwrite        <= 1'b0;
        dmem_hwdata        <= '0;

        void'($urandom(SEED));
        read_trace();
        if (tr_count == 0) begin
            $display("trace file holds no transfers");
            error_count++;
        end
        wait_reset(ok);
        if (ok && tr_count > 0) begin
            replay_trace();
        end

        // One more look at the interrupt lines after the last transfer
        @(posedge clk);
        @(negedge clk);
        check_irq("irq_lines", irq_lines, irq_model);

        $display("tests %0d, failed %0d, errors %0d", tests_run, fail_tests, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/ahb_dual_mem_trace.txt
# port (0 imem, 1 dmem), write (1 = write), size (0 byte, 1 half, 2 word)
# address, write data, expected read data (hex), expected hresp, chain (1 = pipelined)
# Word, halfword and byte writes with read-back
1 1 2 00000010 11223344 00000000 0 0
1 0 2 00000010 00000000 11223344 0 0
1 1 1 00000020 0000aabb 00000000 0 0
1 1 1 00000022 ccdd0000 00000000 0 0
1 0 1 00000020 00000000 0000aabb 0 0
1 0 1 00000022 00000000 ccdd0000 0 1
1 0 2 00000020 00000000 ccddaabb 0 1
1 1 0 00000030 000000a1 00000000 0 0
1 1 0 00000031 0000b200 00000000 0 1
1 1 0 00000032 00c30000 00000000 0 0
1 1 0 00000033 d4000000 00000000 0 1
1 0 0 00000031 00000000 0000b200 0 0
1 0 0 00000033 00000000 d4000000 0 0
1 0 2 00000030 00000000 d4c3b2a1 0 1
1 1 2 00000040 01020304 00000000 0 0
1 1 0 00000041 55667788 00000000 0 0
1 0 0 00000041 00000000 00007700 0 0
1 0 2 00000040 00000000 01027704 0 0
# Instruction fetches of words written on the data port
0 0 2 00000010 00000000 11223344 0 0
0 0 2 00000030 00000000 d4c3b2a1 0 1
0 0 2 00000040 00000000 01027704 0 0
# Read pipelined behind a write to the same word
1 1 2 00000050 cafef00d 00000000 0 0
1 0 2 00000050 00000000 cafef00d 0 1
1 1 0 00000052 00990000 00000000 0 0
1 0 2 00000050 00000000 ca99f00d 0 1
# Fixed error address and error pointer
1 0 2 fffff100 00000000 00000000 1 0
0 0 2 fffff100 00000000 00000000 1 0
1 1 2 f0000200 00000060 00000000 0 0
1 0 2 f0000200 00000000 00000060 0 0
1 0 2 00000060 00000000 00000000 1 0
0 0 2 00000060 00000000 00000000 1 0
1 1 2 00000060 12345678 00000000 1 0
1 0 2 fffff100 00000000 00000000 1 0
# Interrupt-line register
1 1 2 f0000100 000000a5 00000000 0 0
1 0 2 f0000100 00000000 000000a5 0 0
1 1 2 f0000100 0000015a 00000000 0 0
1 0 2 f0000100 00000000 0000005a 0 1
1 0 2 f0000200 00000000 00000060 0 1

// File: sim/tb_clk_gen.sv
/*
 * Clock and synchronous reset source for the testbench
 */
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset held low for a fixed number of rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire
